//--- Bender.yml
package:
  name: ati_perp_bridge

sources:
  # Packages before the modules that use them
  - hdl/ati_bus_pkg.sv
  - hdl/ati_dev_pkg.sv
  # Write path
  - hdl/ati_wr_queue.sv
  - hdl/ati_byte_serializer.sv
  # Read path
  - hdl/ati_rx_packer.sv
  - hdl/ati_rx_block_buffer.sv
  # Top level
  - hdl/ati_perp_bridge.sv
  - target: test
    files:
      - bench/ati_perp_bridge_tb.sv

//--- ati_perp_bridge.f
hdl/ati_bus_pkg.sv
hdl/ati_dev_pkg.sv
hdl/ati_wr_queue.sv
hdl/ati_byte_serializer.sv
hdl/ati_rx_packer.sv
hdl/ati_rx_block_buffer.sv
hdl/ati_perp_bridge.sv
bench/ati_perp_bridge_tb.sv

//--- bench/ati_perp_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ati_perp_bridge_tb;

    localparam int CH_ID        = 1;
    localparam int TIMEOUT      = 16;
    localparam int RESET_CYCLES = 5;
    localparam int N_RAND_WR    = 12;
    localparam int DRIVE_DELAY  = 2;
    // Summed worst case length of the tests in cycles
    localparam int TEST_CYCLES  = RESET_CYCLES + N_RAND_WR * 20 + 90 + 20
                                + 2 * (TIMEOUT + 12) + 24 + 50;
    localparam int CYCLE_LIMIT  = 5 * TEST_CYCLES;

    logic                  clk;
    logic                  rst_n;
    ati_bus_pkg::bus_req_t bus_req;
    logic [63:0]           bus_rdata;
    logic                  bus_rd_available;
    logic                  bus_wr_available;
    logic [7:0]            dev_wdata;
    logic                  dev_wr_req;
    logic                  dev_wr_available;
    logic [7:0]            dev_rdata = 8'h00;
    logic                  dev_rd_available = 1'b0;
    logic                  dev_rd_req;

    integer seed;
    int     errors;
    int     checks;
    int     cycle_cnt;
    int     dev_byte_cnt;

    // Expected device bytes and bus read words in arrival order
    logic [7:0]  exp_bytes[$];
    logic [63:0] exp_words[$];
    logic [63:0] exp_masks[$];

    // Bytes the device model still has to hand over
    logic [7:0] src_q[$];
    logic       next_avail;
    logic [7:0] next_rdata;

    // Read handshake seen at the previous edge
    logic rd_req_q;
    logic rd_avail_q;

    ati_perp_bridge #(
        .CHANNEL_ID    (CH_ID),
        .PACKET_TIMEOUT(TIMEOUT)
    ) ati_perp_bridge_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus_req         (bus_req),
        .bus_rdata       (bus_rdata),
        .bus_rd_available(bus_rd_available),
        .bus_wr_available(bus_wr_available),
        .dev_wdata       (dev_wdata),
        .dev_wr_req      (dev_wr_req),
        .dev_wr_available(dev_wr_available),
        .dev_rdata       (dev_rdata),
        .dev_rd_available(dev_rd_available),
        .dev_rd_req      (dev_rd_req)
    );

    always #10 clk = ~clk;

    // Number of device bytes per bus write
    function automatic int write_len(input ati_bus_pkg::data_type_e dt);
        case (dt)
            ati_bus_pkg::DT_WORD: return 4;
            ati_bus_pkg::DT_DWORD: return 8;
            default: return 1;
        endcase
    endfunction

    // Byte idx of the write data counted from the LSB
    function automatic logic [7:0] write_byte(input logic [63:0] data, input int idx);
        return 8'(data >> (8 * idx));
    endfunction

    // Bus word of a block read with list byte k at bits 8k+7:8k
    function automatic logic [63:0] read_word(input logic [47:0] bytes, input int n,
                                              input ati_bus_pkg::data_type_e dt);
        if (dt == ati_bus_pkg::DT_DWORD) begin
            return {bytes, 16'(n)};
        end
        return {32'b0, bytes[23:0], 8'(n)};
    endfunction

    // Slots past the count of a partial block hold stale data
    function automatic logic [63:0] read_mask(input int n, input ati_bus_pkg::data_type_e dt);
        logic [63:0] m;
        if (dt == ati_bus_pkg::DT_DWORD) begin
            return '1;
        end
        m = {32'hffff_ffff, 24'h0, 8'hff};
        for (int k = 0; k < n; k++) begin
            m[8 + 8 * k +: 8] = 8'hff;
        end
        return m;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic bus_write(input logic [1:0] ch, input logic [63:0] data,
                             input ati_bus_pkg::data_type_e dt);
        while (!bus_wr_available) begin
            next_cycle();
        end
        if (ch == 2'(CH_ID)) begin
            for (int k = 0; k < write_len(dt); k++) begin
                exp_bytes.push_back(write_byte(data, k));
            end
        end
        bus_req.addr  = {ch, 30'b0, $random(seed)};
        bus_req.wdata = data;
        bus_req.dtype = dt;
        bus_req.wr    = 1'b1;
        next_cycle();
        bus_req.wr    = 1'b0;
    endtask

    task automatic bus_read(input ati_bus_pkg::data_type_e dt, input logic [47:0] bytes,
                            input int n);
        bus_req.addr  = {2'(CH_ID), 62'b0};
        bus_req.dtype = dt;
        // Available level depends on the size on the bus
        @(posedge clk);
        while (!bus_rd_available) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        exp_words.push_back(read_word(bytes, n, dt));
        exp_masks.push_back(read_mask(n, dt));
        bus_req.rd = 1'b1;
        next_cycle();
        bus_req.rd    = 1'b0;
        bus_req.dtype = ati_bus_pkg::DT_WORD;
    endtask

    // Hand n random bytes to the device model
    task automatic send_bytes(input int n, output logic [47:0] bytes);
        logic [7:0] b;
        bytes = '0;
        for (int k = 0; k < n; k++) begin
            b = 8'($random(seed));
            bytes[8 * k +: 8] = b;
            src_q.push_back(b);
        end
    endtask

    task automatic wait_drained();
        while (exp_bytes.size() != 0) begin
            next_cycle();
        end
    endtask

    // Device read side drops its byte at the edge that ends the req cycle
    always @(posedge clk) begin
        if (rst_n && dev_rd_req && src_q.size() != 0) begin
            void'(src_q.pop_front());
        end
        next_avail = src_q.size() != 0;
        next_rdata = next_avail ? src_q[0] : 8'h00;
        #DRIVE_DELAY;
        dev_rd_available = next_avail;
        dev_rdata        = next_rdata;
    end

    // Compare device bytes and bus reads against the references
    always @(posedge clk) begin : compare_proc
        logic [7:0]  exp_b;
        logic [63:0] exp_w;
        logic [63:0] exp_m;
        if (rst_n && dev_wr_req && dev_wr_available) begin
            dev_byte_cnt++;
            checks++;
            assert (exp_bytes.size() != 0) else begin
                errors++;
                $display("Device got byte %h that no write asked for at %0t", dev_wdata, $time);
            end
            if (exp_bytes.size() != 0) begin
                exp_b = exp_bytes.pop_front();
                assert (dev_wdata == exp_b) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: device byte %h, expected %h",
                             $time, dev_wdata, exp_b);
                end
            end
        end
        if (rst_n && bus_req.rd && bus_rd_available) begin
            checks++;
            assert (exp_words.size() != 0) else begin
                errors++;
                $display("Bus read taken with no read expected at %0t", $time);
            end
            if (exp_words.size() != 0) begin
                exp_w = exp_words.pop_front();
                exp_m = exp_masks.pop_front();
                assert (((bus_rdata ^ exp_w) & exp_m) == '0) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: read word %h, expected %h mask %h",
                             $time, bus_rdata, exp_w, exp_m);
                end
            end
        end
        // Each read req follows a capture cycle with a byte on offer
        if (rst_n && dev_rd_req) begin
            checks++;
            assert (!rd_req_q && rd_avail_q) else begin
                errors++;
                $display("CHECK FAILED at %0t: dev_rd_req high with no byte captured", $time);
            end
        end
        rd_req_q   = dev_rd_req;
        rd_avail_q = dev_rd_available;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            errors++;
            $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Errors found");
            $finish;
        end
    end

    initial begin : stimulus
        logic [47:0]             bytes;
        logic [63:0]             data;
        ati_bus_pkg::data_type_e dt;
        int                      r;
        int                      wait_cnt;
        int                      byte_mark;
        seed             = 57;
        errors           = 0;
        checks           = 0;
        cycle_cnt        = 0;
        dev_byte_cnt     = 0;
        clk              = 1'b0;
        rst_n            = 1'b0;
        bus_req          = '0;
        bus_req.dtype    = ati_bus_pkg::DT_WORD;
        dev_wr_available = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        next_cycle();

        // Random byte, word and dword writes
        for (int i = 0; i < N_RAND_WR; i++) begin
            data = {$random(seed), $random(seed)};
            r    = $unsigned($random(seed)) % 3;
            case (r)
                0: dt = ati_bus_pkg::DT_BYTE;
                1: dt = ati_bus_pkg::DT_WORD;
                default: dt = ati_bus_pkg::DT_DWORD;
            endcase
            bus_write(2'(CH_ID), data, dt);
        end
        wait_drained();

        // Stalled device fills the queue
        dev_wr_available = 1'b0;
        for (int i = 0; i < 3; i++) begin
            checks++;
            assert (bus_wr_available) else begin
                errors++;
                $display("CHECK FAILED at %0t: bus_wr_available low after %0d writes", $time, i);
            end
            bus_write(2'(CH_ID), {$random(seed), $random(seed)}, ati_bus_pkg::DT_DWORD);
        end
        checks++;
        assert (!bus_wr_available) else begin
            errors++;
            $display("CHECK FAILED at %0t: bus_wr_available high with full queue", $time);
        end
        repeat (10) begin
            checks++;
            assert (!dev_wr_req) else begin
                errors++;
                $display("CHECK FAILED at %0t: dev_wr_req high while device busy", $time);
            end
            next_cycle();
        end
        dev_wr_available = 1'b1;
        wait_drained();

        // Full block then word read
        send_bytes(3, bytes);
        bus_read(ati_bus_pkg::DT_WORD, bytes, 3);

        // Partial blocks close on silence
        for (int n = 1; n <= 2; n++) begin
            send_bytes(n, bytes);
            wait_cnt = 0;
            @(posedge clk);
            while (!bus_rd_available) begin
                wait_cnt++;
                @(posedge clk);
            end
            #DRIVE_DELAY;
            checks++;
            assert (wait_cnt >= TIMEOUT && wait_cnt <= TIMEOUT + 4 * n + 8) else begin
                errors++;
                $display("CHECK FAILED at %0t: partial block readable after %0d cycles",
                         $time, wait_cnt);
            end
            bus_read(ati_bus_pkg::DT_WORD, bytes, n);
        end

        // Two blocks in one dword read
        send_bytes(6, bytes);
        bus_read(ati_bus_pkg::DT_DWORD, bytes, 6);

        // Other channel
        byte_mark = dev_byte_cnt;
        for (int i = 0; i < 4; i++) begin
            bus_write(2'd2, {$random(seed), $random(seed)}, ati_bus_pkg::DT_DWORD);
        end
        repeat (40) next_cycle();
        checks++;
        assert (dev_byte_cnt == byte_mark && exp_words.size() == 0) else begin
            errors++;
            $display("CHECK FAILED at %0t: %0d device bytes from channel 2, %0d reads left",
                     $time, dev_byte_cnt - byte_mark, exp_words.size());
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/ati_bus_pkg.sv
`default_nettype none

package ati_bus_pkg;

    // System bus data word
    localparam int BUS_DATA_W = 64;

    // System bus address
    localparam int BUS_ADDR_W = 64;

    // Channel select taken from the top address bits
    localparam int CHANNEL_W = 2;

    // Size of one bus transfer
    typedef enum logic [1:0] {
        DT_BYTE  = 2'd0,
        DT_WORD  = 2'd1,
        DT_DWORD = 2'd2
    } data_type_e;

    // One transaction as presented by the bus master
    typedef struct packed {
        // Channel in the top bits, rest unused by this slave
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] wdata;
        data_type_e            dtype;
        // One-cycle requests, at most one high
        logic                  rd;
        logic                  wr;
    } bus_req_t;

    // Queued write, waiting for the serializer
    typedef struct packed {
        logic [BUS_DATA_W-1:0] data;
        // Decides how many bytes leave towards the device
        data_type_e            dtype;
    } wr_entry_t;

endpackage

`default_nettype wire

//--- hdl/ati_byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module ati_byte_serializer (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire ati_bus_pkg::wr_entry_t        front,
    input  wire                                not_empty,
    output logic                               pop,
    input  wire                                dev_wr_available,
    output logic [ati_dev_pkg::DEV_DATA_W-1:0] dev_wdata,
    output logic                               dev_wr_req
);

    localparam int DW    = ati_dev_pkg::DEV_DATA_W;
    localparam int IDX_W = $clog2(ati_bus_pkg::BUS_DATA_W / DW);

    logic [IDX_W-1:0] byte_idx;
    logic [IDX_W-1:0] last_idx;
    logic             advance;
    logic             last_load;

    // Last byte index from the transfer size
    always_comb begin
        case (front.dtype)
            ati_bus_pkg::DT_WORD: begin
                last_idx = IDX_W'(3);
            end
            ati_bus_pkg::DT_DWORD: begin
                last_idx = IDX_W'(7);
            end
            default: begin
                last_idx = IDX_W'(0);
            end
        endcase
    end

    // Byte mux, LSB first
    assign dev_wdata = front.data[byte_idx*DW +: DW];

    // Stall in place while device is busy
    assign advance = not_empty && dev_wr_available;

    // Load cycle of the final byte frees the queue entry
    assign last_load = dev_wr_req && (byte_idx == last_idx);
    assign pop       = advance && last_load;

    // Req low is the sample cycle, req high the load cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dev_wr_req <= 1'b0;
            byte_idx   <= '0;
        end else if (advance) begin
            dev_wr_req <= !dev_wr_req;
            if (dev_wr_req) begin
                // Device took the byte, step to the next one
                if (last_load) begin
                    byte_idx <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ati_dev_pkg.sv
`default_nettype none

package ati_dev_pkg;

    // Byte-wide device port
    localparam int DEV_DATA_W = 8;

    // Word block layout, slot 0 count and slots 1..3 data
    localparam int BLOCK_BYTES = 4;
    localparam int SLOT_W      = 2;
    localparam logic [SLOT_W-1:0] FIRST_SLOT = SLOT_W'(1);
    localparam logic [SLOT_W-1:0] LAST_SLOT  = SLOT_W'(BLOCK_BYTES - 1);

    // Byte count of a block fills the whole count slot
    localparam int COUNT_W = DEV_DATA_W;

    // Widest block index carried between packer and buffer
    localparam int BLK_IDX_W = 8;

    // Packer states
    typedef enum logic {
        RX_IDLE     = 1'b0,
        RX_IN_BLOCK = 1'b1
    } rx_state_e;

    // One packer write into the block buffer
    typedef struct packed {
        logic                  byte_wr;
        // Current block, upper bits zero
        logic [BLK_IDX_W-1:0]  blk_idx;
        logic [SLOT_W-1:0]     slot;
        logic [DEV_DATA_W-1:0] data;
        // Block done, store count and mark valid
        logic                  close;
        logic [COUNT_W-1:0]    count;
    } blk_wr_t;

endpackage

`default_nettype wire

//--- hdl/ati_perp_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module ati_perp_bridge #(
    parameter int unsigned CHANNEL_ID     = 0,
    parameter int unsigned WQ_DEPTH       = 4,
    parameter int unsigned RX_BLOCKS      = 8,
    parameter int unsigned PACKET_TIMEOUT = 260416
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire ati_bus_pkg::bus_req_t          bus_req,
    output logic [ati_bus_pkg::BUS_DATA_W-1:0]  bus_rdata,
    output logic                                bus_rd_available,
    output logic                                bus_wr_available,
    output logic [ati_dev_pkg::DEV_DATA_W-1:0]  dev_wdata,
    output logic                                dev_wr_req,
    input  wire                                 dev_wr_available,
    input  wire  [ati_dev_pkg::DEV_DATA_W-1:0]  dev_rdata,
    input  wire                                 dev_rd_available,
    output logic                                dev_rd_req
);

    localparam int CH_W = ati_bus_pkg::CHANNEL_W;
    localparam int AW   = ati_bus_pkg::BUS_ADDR_W;

    logic                   chan_match;
    logic                   wr_push;
    logic                   rd_pop;
    logic                   q_full;
    logic                   q_not_empty;
    logic                   q_pop;
    ati_bus_pkg::wr_entry_t push_entry;
    ati_bus_pkg::wr_entry_t q_front;
    ati_dev_pkg::blk_wr_t   blk_wr;
    logic                   buf_full;

    // Channel decode on the top address bits
    assign chan_match = bus_req.addr[AW-1 -: CH_W] == CH_W'(CHANNEL_ID);
    assign wr_push    = chan_match && bus_req.wr;
    assign rd_pop     = chan_match && bus_req.rd;

    always_comb begin
        push_entry.data  = bus_req.wdata;
        push_entry.dtype = bus_req.dtype;
    end

    // Full queue holds off the master
    assign bus_wr_available = !q_full;

    // Write path, queue then serializer
    ati_wr_queue #(
        .WQ_DEPTH(WQ_DEPTH)
    ) wr_queue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_push),
        .push_entry(push_entry),
        .pop       (q_pop),
        .front     (q_front),
        .not_empty (q_not_empty),
        .full      (q_full)
    );

    ati_byte_serializer byte_serializer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .front           (q_front),
        .not_empty       (q_not_empty),
        .pop             (q_pop),
        .dev_wr_available(dev_wr_available),
        .dev_wdata       (dev_wdata),
        .dev_wr_req      (dev_wr_req)
    );

    // Read path, packer then block buffer
    ati_rx_packer #(
        .RX_BLOCKS     (RX_BLOCKS),
        .PACKET_TIMEOUT(PACKET_TIMEOUT)
    ) rx_packer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .dev_rdata       (dev_rdata),
        .dev_rd_available(dev_rd_available),
        .dev_rd_req      (dev_rd_req),
        .buf_full        (buf_full),
        .blk_wr          (blk_wr)
    );

    // Read answer follows the request size of the current cycle
    ati_rx_block_buffer #(
        .RX_BLOCKS(RX_BLOCKS)
    ) rx_block_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_wr      (blk_wr),
        .buf_full    (buf_full),
        .rd_type     (bus_req.dtype),
        .rd_pop      (rd_pop),
        .rd_available(bus_rd_available),
        .rdata       (bus_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/ati_rx_block_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module ati_rx_block_buffer #(
    parameter int unsigned RX_BLOCKS = 8
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire ati_dev_pkg::blk_wr_t            blk_wr,
    output logic                                 buf_full,
    input  wire ati_bus_pkg::data_type_e         rd_type,
    input  wire                                  rd_pop,
    output logic                                 rd_available,
    output logic [ati_bus_pkg::BUS_DATA_W-1:0]   rdata
);

    // Block count is a power of two, indices wrap on their own
    localparam int IDX_W = $clog2(RX_BLOCKS);
    localparam int W     = ati_dev_pkg::DEV_DATA_W;
    localparam int HI_W  = ati_bus_pkg::BUS_DATA_W - ati_dev_pkg::BLOCK_BYTES * W;

    // Byte array, slot 0 of each block holds its count
    logic [W-1:0] mem [RX_BLOCKS][ati_dev_pkg::BLOCK_BYTES];

    logic [RX_BLOCKS-1:0] valid;
    logic [IDX_W-1:0]     rd_blk;
    logic [IDX_W-1:0]     rd_blk_next;
    logic [IDX_W-1:0]     wr_blk;
    logic [IDX_W-1:0]     wr_blk_next;
    logic [3*W-1:0]       data_lo;
    logic [3*W-1:0]       data_hi;
    logic [2*W-1:0]       cnt_sum;
    logic                 dword;
    logic                 take;

    assign wr_blk      = blk_wr.blk_idx[IDX_W-1:0];
    assign wr_blk_next = wr_blk + 1'b1;
    assign rd_blk_next = rd_blk + 1'b1;

    // Packer may not step onto the oldest unread block
    assign buf_full = rd_blk == wr_blk_next;

    // Data bytes and count land in separate slots
    always_ff @(posedge clk) begin
        if (blk_wr.byte_wr) begin
            mem[wr_blk][blk_wr.slot] <= blk_wr.data;
        end
        if (blk_wr.close) begin
            mem[wr_blk][0] <= blk_wr.count;
        end
    end

    // Current block in the low word, next block above it
    assign data_lo = {mem[rd_blk][3], mem[rd_blk][2], mem[rd_blk][1]};
    assign data_hi = {mem[rd_blk_next][3], mem[rd_blk_next][2], mem[rd_blk_next][1]};
    assign cnt_sum = {{W{1'b0}}, mem[rd_blk][0]} + {{W{1'b0}}, mem[rd_blk_next][0]};

    // Bus view, follows the request size
    always_comb begin
        case (rd_type)
            ati_bus_pkg::DT_BYTE, ati_bus_pkg::DT_WORD: begin
                rd_available = valid[rd_blk];
                rdata        = {{HI_W{1'b0}}, data_lo, mem[rd_blk][0]};
            end
            ati_bus_pkg::DT_DWORD: begin
                // Needs both blocks closed
                rd_available = valid[rd_blk] && valid[rd_blk_next];
                rdata        = {data_hi, data_lo, cnt_sum};
            end
            default: begin
                rd_available = 1'b0;
                rdata        = '0;
            end
        endcase
    end

    assign dword = rd_type == ati_bus_pkg::DT_DWORD;
    assign take  = rd_pop && rd_available;

    // Close sets a flag, read clears one or two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_blk <= '0;
            valid  <= '0;
        end else begin
            if (take) begin
                rd_blk <= dword ? rd_blk_next + 1'b1 : rd_blk_next;
            end
            for (int i = 0; i < RX_BLOCKS; i++) begin
                // Never the same block, close hits only invalid ones
                if (blk_wr.close && (wr_blk == IDX_W'(i))) begin
                    valid[i] <= 1'b1;
                end else if (take && ((rd_blk == IDX_W'(i))
                             || (dword && (rd_blk_next == IDX_W'(i))))) begin
                    valid[i] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ati_rx_packer.sv
`timescale 1ns/1ps
`default_nettype none

module ati_rx_packer #(
    parameter int unsigned RX_BLOCKS      = 8,
    parameter int unsigned PACKET_TIMEOUT = 260416
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [ati_dev_pkg::DEV_DATA_W-1:0]   dev_rdata,
    input  wire                                  dev_rd_available,
    output logic                                 dev_rd_req,
    input  wire                                  buf_full,
    output ati_dev_pkg::blk_wr_t                 blk_wr
);

    localparam int IDX_W = $clog2(RX_BLOCKS);
    localparam int PAD_W = ati_dev_pkg::BLK_IDX_W - IDX_W;
    localparam int TO_W  = $clog2(PACKET_TIMEOUT + 1);
    localparam logic [TO_W-1:0] TO_LIMIT = TO_W'(PACKET_TIMEOUT);

    ati_dev_pkg::rx_state_e state;

    // Write pointer is block index plus slot
    logic [IDX_W-1:0]                 wr_blk;
    logic [ati_dev_pkg::SLOT_W-1:0]   slot;
    logic [ati_dev_pkg::COUNT_W-1:0]  byte_cnt;
    logic [TO_W-1:0]                  silence_cnt;

    logic in_block;
    logic capture;
    logic pop_byte;
    logic slot_wrap;
    logic timed_out;
    logic close;

    assign in_block = state == ati_dev_pkg::RX_IN_BLOCK;

    // Capture and pop alternate, req high marks the pop cycle
    assign pop_byte = in_block && dev_rd_req;
    assign capture  = in_block && !dev_rd_req && dev_rd_available;

    // Third data byte popped
    assign slot_wrap = pop_byte && (slot == ati_dev_pkg::LAST_SLOT);

    // Quiet device long enough, partial block with data only
    assign timed_out = in_block && !dev_rd_req && !dev_rd_available
                    && (silence_cnt == TO_LIMIT) && (byte_cnt != '0);

    assign close = slot_wrap || timed_out;

    // Write port of the block buffer, driven every cycle
    always_comb begin
        blk_wr.byte_wr = capture;
        blk_wr.blk_idx = {{PAD_W{1'b0}}, wr_blk};
        blk_wr.slot    = slot;
        blk_wr.data    = dev_rdata;
        blk_wr.close   = close;
        blk_wr.count   = byte_cnt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ati_dev_pkg::RX_IDLE;
            wr_blk      <= '0;
            slot        <= ati_dev_pkg::FIRST_SLOT;
            byte_cnt    <= '0;
            silence_cnt <= '0;
            dev_rd_req  <= 1'b0;
        end else begin
            case (state)
                ati_dev_pkg::RX_IDLE: begin
                    silence_cnt <= '0;
                    // Wait for a free block
                    if (!buf_full) begin
                        state    <= ati_dev_pkg::RX_IN_BLOCK;
                        byte_cnt <= '0;
                    end
                end
                ati_dev_pkg::RX_IN_BLOCK: begin
                    if (pop_byte) begin
                        // Device drops the byte at this edge
                        dev_rd_req  <= 1'b0;
                        silence_cnt <= '0;
                        if (!slot_wrap) begin
                            slot <= slot + 1'b1;
                        end
                    end else if (capture) begin
                        dev_rd_req  <= 1'b1;
                        byte_cnt    <= byte_cnt + 1'b1;
                        silence_cnt <= '0;
                    end else if (silence_cnt != TO_LIMIT) begin
                        // Saturates, an empty block just waits
                        silence_cnt <= silence_cnt + 1'b1;
                    end
                    // Block done, next block from slot 1
                    if (close) begin
                        state  <= ati_dev_pkg::RX_IDLE;
                        wr_blk <= wr_blk + 1'b1;
                        slot   <= ati_dev_pkg::FIRST_SLOT;
                    end
                end
                default: begin
                    state <= ati_dev_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/ati_wr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ati_wr_queue #(
    parameter int unsigned WQ_DEPTH = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire ati_bus_pkg::wr_entry_t push_entry,
    input  wire                         pop,
    output ati_bus_pkg::wr_entry_t      front,
    output logic                        not_empty,
    output logic                        full
);

    // Depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(WQ_DEPTH);

    ati_bus_pkg::wr_entry_t mem [WQ_DEPTH];

    logic [PTR_W-1:0] front_ptr;
    logic [PTR_W-1:0] rear_ptr;
    logic [PTR_W-1:0] rear_next;

    // One slot kept free to tell full from empty
    assign rear_next = rear_ptr + 1'b1;
    assign full      = rear_next == front_ptr;
    assign not_empty = rear_ptr != front_ptr;

    // Head entry straight to the serializer
    assign front = mem[front_ptr];

    // Entry storage
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[rear_ptr] <= push_entry;
        end
    end

    // Rear moves on accepted push, push into full queue is lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rear_ptr <= '0;
        end else if (push && !full) begin
            rear_ptr <= rear_next;
        end
    end

    // Front moves once the last byte of the head entry is loaded
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            front_ptr <= '0;
        end else if (pop && not_empty) begin
            front_ptr <= front_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire
